//--- verilog/sensor_pkg.sv
package sensor_pkg;

   // bus and counter widths
   localparam int PIX_W   = 10;
   localparam int ROW_W   = 12;
   localparam int COL_W   = 12;
   localparam int NOISE_W = 32;
   localparam int FRAME_W = 16;

   // one pixel on the sensor bus
   typedef logic [PIX_W-1:0] pix_t;

   // row and column counts, also used for sizes
   typedef logic [ROW_W-1:0] row_t;
   typedef logic [COL_W-1:0] col_t;

   // LFSR state and its seed
   typedef logic [NOISE_W-1:0] noise_t;

   // frames since reset
   typedef logic [FRAME_W-1:0] frame_cnt_t;

   // source of the active pixel values
   typedef enum logic [2:0] {
      mode_noise      = 3'd0,
      mode_hgrad      = 3'd1,
      mode_vgrad      = 3'd2,
      mode_diag       = 3'd3,
      mode_frame      = 3'd4,
      mode_frame_diag = 3'd5,
      mode_image      = 3'd6
   } pattern_mode_e;

   // scan geometry, blanking counted as virtual rows and columns
   typedef struct packed {
      row_t active_rows;
      row_t virtual_rows;
      col_t active_cols;
      col_t virtual_cols;
   } scan_geom_s;

endpackage

//--- verilog/mem_pkg.sv
package mem_pkg;

   // image edge length, the stored image wraps beyond it
   localparam int MEM_SIDE = 64;
   localparam int SIDE_W   = $clog2(MEM_SIDE);
   localparam int ADDR_W   = 2 * SIDE_W;

   // row low bits above active column low bits
   typedef logic [ADDR_W-1:0] addr_t;

   // host write, valid for one cycle per write
   typedef struct packed {
      logic             valid;
      addr_t            addr;
      sensor_pkg::pix_t data;
   } mem_wr_s;

   // generator read request
   typedef struct packed {
      logic  valid;
      addr_t addr;
   } mem_rd_s;

endpackage

//--- verilog/pattern_gen.sv
module pattern_gen (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  sensor_pkg::pattern_mode_e mode,
   input  sensor_pkg::scan_geom_s    geom,
   input  sensor_pkg::noise_t        noise_seed,
   input  sensor_pkg::pix_t          rd_data,
   output mem_pkg::mem_rd_s          rd_req,
   output sensor_pkg::pix_t          dat,
   output logic                      fv,
   output logic                      lv
);

   // scan state
   sensor_pkg::row_t       row_cnt;
   sensor_pkg::col_t       col_cnt;
   sensor_pkg::frame_cnt_t frame_cnt;
   sensor_pkg::noise_t     noise;

   // one extra bit so sums of two sizes do not wrap
   logic [sensor_pkg::ROW_W:0] total_rows;
   logic [sensor_pkg::ROW_W:0] row_nxt;
   logic [sensor_pkg::COL_W:0] total_cols;
   logic [sensor_pkg::COL_W:0] col_nxt;
   logic [sensor_pkg::COL_W:0] lv_end;

   sensor_pkg::col_t hblank_fp;
   sensor_pkg::col_t act_col;

   logic fv_w;
   logic lv_w;
   logic fv_s;
   logic lv_s;
   logic img_s;
   logic noise_fb;

   sensor_pkg::pix_t dat_sel;

   // stage one outputs
   logic             p1_fv;
   logic             p1_lv;
   logic             p1_img;
   sensor_pkg::pix_t p1_dat;

   assign total_rows = {1'b0, geom.active_rows} + {1'b0, geom.virtual_rows};
   assign total_cols = {1'b0, geom.active_cols} + {1'b0, geom.virtual_cols};
   assign row_nxt    = {1'b0, row_cnt} + 1'b1;
   assign col_nxt    = {1'b0, col_cnt} + 1'b1;

   // front porch is half the horizontal blanking
   assign hblank_fp = geom.virtual_cols >> 1;
   assign lv_end    = {1'b0, geom.active_cols} + {1'b0, hblank_fp};
   assign act_col   = col_cnt - hblank_fp;

   assign fv_w = (row_cnt < geom.active_rows);
   assign lv_w = fv_w && (col_cnt >= hblank_fp) && ({1'b0, col_cnt} < lv_end);

   // a disabled generator produces no pixels
   assign fv_s  = enable && fv_w;
   assign lv_s  = enable && lv_w;
   assign img_s = lv_s && (mode == sensor_pkg::mode_image);

   assign noise_fb = ~(noise[31] ^ noise[21] ^ noise[1] ^ noise[0]);

   // memory read for the pixel at the current counters
   always_comb begin
      rd_req.valid = img_s;
      rd_req.addr  = {row_cnt[mem_pkg::SIDE_W-1:0], act_col[mem_pkg::SIDE_W-1:0]};
   end

   // locally computed patterns, sums wrap at the pixel width
   always_comb begin
      case (mode)
         sensor_pkg::mode_noise:      dat_sel = noise[sensor_pkg::PIX_W-1:0];
         sensor_pkg::mode_hgrad:      dat_sel = row_cnt[sensor_pkg::PIX_W-1:0];
         sensor_pkg::mode_vgrad:      dat_sel = col_cnt[sensor_pkg::PIX_W-1:0];
         sensor_pkg::mode_diag:       dat_sel = row_cnt[sensor_pkg::PIX_W-1:0]
                                              + col_cnt[sensor_pkg::PIX_W-1:0];
         sensor_pkg::mode_frame:      dat_sel = frame_cnt[sensor_pkg::PIX_W-1:0];
         sensor_pkg::mode_frame_diag: dat_sel = frame_cnt[sensor_pkg::PIX_W-1:0]
                                              + col_cnt[sensor_pkg::PIX_W-1:0]
                                              + row_cnt[sensor_pkg::PIX_W-1:0];
         // image data joins in stage two
         default:                     dat_sel = '0;
      endcase
   end

   // row, column and frame counters
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         row_cnt   <= '0;
         col_cnt   <= '0;
         frame_cnt <= '0;
      end else if (!enable) begin
         // restart at row 0, frame count held
         row_cnt <= '0;
         col_cnt <= '0;
      end else if (col_nxt >= total_cols) begin
         col_cnt <= '0;
         if (row_nxt >= total_rows) begin
            row_cnt   <= '0;
            frame_cnt <= frame_cnt + 1'b1;
         end else begin
            row_cnt <= row_nxt[sensor_pkg::ROW_W-1:0];
         end
      end else begin
         col_cnt <= col_nxt[sensor_pkg::COL_W-1:0];
      end
   end

   // noise LFSR
   // a zero seed lets each frame continue the sequence
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         noise <= sensor_pkg::noise_t'(1);
      end else if (!fv_w) begin
         if (|noise_seed) begin
            noise <= noise_seed;
         end
      end else if (lv_s) begin
         noise <= {noise[sensor_pkg::NOISE_W-2:0], noise_fb};
      end
   end

   // stage one, sync levels and local pixel
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         p1_fv  <= 1'b0;
         p1_lv  <= 1'b0;
         p1_img <= 1'b0;
         p1_dat <= '0;
      end else begin
         p1_fv  <= fv_s;
         p1_lv  <= lv_s;
         p1_img <= img_s;
         p1_dat <= lv_s ? dat_sel : '0;
      end
   end

   // stage two, memory data arrives alongside stage one
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         fv  <= 1'b0;
         lv  <= 1'b0;
         dat <= '0;
      end else begin
         fv  <= p1_fv;
         lv  <= p1_lv;
         dat <= p1_img ? rd_data : p1_dat;
      end
   end

endmodule

//--- verilog/frame_mem.sv
module frame_mem (
   input  logic             clk,
   input  logic             en,
   input  logic             we,
   input  mem_pkg::addr_t   addr,
   input  sensor_pkg::pix_t wdata,
   output sensor_pkg::pix_t rdata
);

   localparam int DEPTH = mem_pkg::MEM_SIDE * mem_pkg::MEM_SIDE;

   // one word per stored pixel
   sensor_pkg::pix_t mem [DEPTH];

   // write port
   always_ff @(posedge clk) begin
      if (en && we) begin
         mem[addr] <= wdata;
      end
   end

   // registered read, data valid the cycle after the request
   always_ff @(posedge clk) begin
      if (en && !we) begin
         rdata <= mem[addr];
      end
   end

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter (
   input  logic               clk,
   input  logic               reset_n,
   input  mem_pkg::mem_rd_s   rd_req,
   input  mem_pkg::mem_wr_s   host_wr,
   output logic               host_busy,
   output logic               mem_en,
   output logic               mem_we,
   output mem_pkg::addr_t     mem_addr,
   output sensor_pkg::pix_t   mem_wdata
);

   // one-entry holding register for host writes
   logic             pend_valid;
   mem_pkg::addr_t   pend_addr;
   sensor_pkg::pix_t pend_data;

   logic accept;
   logic drain;

   // writes arriving while one is held are dropped
   assign accept = host_wr.valid && !pend_valid;

   // the held write goes in the first cycle without a read
   assign drain = pend_valid && !rd_req.valid;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pend_valid <= 1'b0;
      end else if (accept) begin
         pend_valid <= 1'b1;
      end else if (drain) begin
         pend_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         pend_addr <= host_wr.addr;
         pend_data <= host_wr.data;
      end
   end

   assign host_busy = pend_valid;

   // generator read wins the port
   assign mem_en    = rd_req.valid || pend_valid;
   assign mem_we    = drain;
   assign mem_addr  = rd_req.valid ? rd_req.addr : pend_addr;
   assign mem_wdata = pend_data;

endmodule

//--- verilog/imager_top.sv
module imager_top (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  sensor_pkg::pattern_mode_e mode,
   input  sensor_pkg::scan_geom_s    geom,
   input  sensor_pkg::noise_t        noise_seed,
   input  mem_pkg::mem_wr_s          host_wr,
   output sensor_pkg::pix_t          dat,
   output logic                      fv,
   output logic                      lv,
   output logic                      host_busy
);

   // generator read path
   mem_pkg::mem_rd_s rd_req;
   sensor_pkg::pix_t rd_data;

   // shared memory port
   logic             mem_en;
   logic             mem_we;
   mem_pkg::addr_t   mem_addr;
   sensor_pkg::pix_t mem_wdata;

   pattern_gen u_gen (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .mode       (mode),
      .geom       (geom),
      .noise_seed (noise_seed),
      .rd_data    (rd_data),
      .rd_req     (rd_req),
      .dat        (dat),
      .fv         (fv),
      .lv         (lv)
   );

   mem_arbiter u_arb (
      .clk       (clk),
      .reset_n   (reset_n),
      .rd_req    (rd_req),
      .host_wr   (host_wr),
      .host_busy (host_busy),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata)
   );

   frame_mem u_mem (
      .clk   (clk),
      .en    (mem_en),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (rd_data)
   );

endmodule

//--- sim/imager_chk.sv
module imager_chk (
   input logic                   clk,
   input logic                   reset_n,
   input logic                   enable,
   input sensor_pkg::scan_geom_s geom,
   input sensor_pkg::pix_t       dat,
   input logic                   fv,
   input logic                   lv,
   input logic                   host_busy
);

   timeunit 1ns;
   timeprecision 1ps;

   int   fail_cnt = 0;
   int   busy_run;
   int   line_len;
   logic seen_en;

   assign line_len = int'(geom.active_cols) + int'(geom.virtual_cols);

   // consecutive cycles with a host write held
   always @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         busy_run <= 0;
         seen_en  <= 1'b0;
      end else begin
         busy_run <= host_busy ? busy_run + 1 : 0;
         if (enable) begin
            seen_en <= 1'b1;
         end
      end
   end

   a_lv_in_fv : assert property (@(posedge clk) disable iff (!reset_n) lv |-> fv)
      else begin
         fail_cnt++;
         $error("lv high outside fv");
      end

   a_dat_blank : assert property (@(posedge clk) disable iff (!reset_n) !lv |-> dat == '0)
      else begin
         fail_cnt++;
         $error("dat not zero outside lv");
      end

   // held write drains within one line
   a_busy_len : assert property (@(posedge clk) disable iff (!reset_n) busy_run <= line_len)
      else begin
         fail_cnt++;
         $error("host_busy high longer than one line");
      end

   a_quiet : assert property (@(posedge clk) disable iff (!reset_n)
                              !seen_en |-> (!fv && !lv && dat == '0))
      else begin
         fail_cnt++;
         $error("sensor bus active before first enable");
      end

endmodule

//--- sim/imager_monitor.sv
module imager_monitor (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  sensor_pkg::pattern_mode_e mode,
   input  sensor_pkg::scan_geom_s    geom,
   input  sensor_pkg::noise_t        noise_seed,
   input  mem_pkg::mem_wr_s          host_wr,
   input  logic                      host_busy,
   input  sensor_pkg::pix_t          dat,
   input  logic                      fv,
   input  logic                      lv,
   output int                        err_cnt,
   output int                        frames_done,
   output int                        img_checked
);

   timeunit 1ns;
   timeprecision 1ps;

   // host writes as seen at the strobe, and the copy valid for the current frame
   logic [9:0] img_model [4096];
   bit         img_ok    [4096];
   logic [9:0] frame_img [4096];
   bit         frame_ok  [4096];

   logic [31:0] noise_m;
   logic [2:0]  frame_mode;
   logic [9:0]  expected;
   logic        fv_q;
   logic        lv_q;
   bit          dropped;
   bit          vblank_seen;
   bit          last_complete;
   bit          busy_due;
   int          cyc;
   int          fv_rise_cyc;
   int          lv_rise_cyc;
   int          line;
   int          col;
   int          frame_m;
   int          dis_cnt;
   int          addr;
   int          line_cycles;
   int          frame_cycles;

   function automatic logic [31:0] lfsr_step(input logic [31:0] n);
      return {n[30:0], ~(n[31] ^ n[21] ^ n[1] ^ n[0])};
   endfunction

   // expected active pixel, col is counted from the start of lv
   function automatic logic [9:0] ref_pixel(input logic [2:0] m,
                                            input sensor_pkg::scan_geom_s g,
                                            input int row, input int ci,
                                            input int frame, input logic [31:0] nz);
      int full_col;
      full_col = ci + int'(g.virtual_cols / 2);
      case (m)
         3'd0:    return nz[9:0];
         3'd1:    return 10'(row);
         3'd2:    return 10'(full_col);
         3'd3:    return 10'(row + full_col);
         3'd4:    return 10'(frame);
         3'd5:    return 10'(frame + full_col + row);
         3'd6:    return frame_img[(row % 64) * 64 + (ci % 64)];
         default: return 10'd0;
      endcase
   endfunction

   always @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         noise_m = 32'd1;
         fv_q = 1'b0;
         lv_q = 1'b0;
         dropped = 0;
         vblank_seen = 0;
         last_complete = 0;
         busy_due = 0;
         cyc = 0;
         line = 0;
         col = 0;
         frame_m = 0;
         dis_cnt = 0;
         err_cnt = 0;
         frames_done = 0;
         img_checked = 0;
         frame_mode = 3'd0;
         for (int i = 0; i < 4096; i++) begin
            img_ok[i] = 0;
            frame_ok[i] = 0;
         end
      end else begin
         cyc++;
         // line and frame lengths in clocks, blanking included
         line_cycles  = int'(geom.active_cols) + int'(geom.virtual_cols);
         frame_cycles = line_cycles * (int'(geom.active_rows) + int'(geom.virtual_rows));
         dis_cnt = enable ? 0 : dis_cnt + 1;
         if (dis_cnt >= 3 && (fv || lv || dat != '0)) begin
            $display("[ERROR] fv/lv/dat after disable expected 0 actual %h/%h/%h", fv, lv, dat);
            err_cnt++;
         end
         if (!enable && fv) begin
            dropped = 1;
         end
         if (fv && !fv_q) begin
            // new frame, after a full vblank the seed has been reloaded
            if (vblank_seen && noise_seed != '0) begin
               noise_m = noise_seed;
            end
            if (last_complete && cyc - fv_rise_cyc != frame_cycles) begin
               $display("[ERROR] fv period expected %h actual %h",
                        frame_cycles, cyc - fv_rise_cyc);
               err_cnt++;
            end
            vblank_seen = 0;
            fv_rise_cyc = cyc;
            line = 0;
            frame_mode = mode;
            for (int i = 0; i < 4096; i++) begin
               frame_img[i] = img_model[i];
               frame_ok[i] = img_ok[i];
            end
         end
         // an accepted write holds the port busy on the next cycle
         if (busy_due && !host_busy) begin
            $display("[ERROR] host_busy after accepted write expected %h actual %h",
                     1'b1, host_busy);
            err_cnt++;
         end
         busy_due = host_wr.valid && !host_busy;
         // accepted host writes, uncertain for the frame in progress
         if (host_wr.valid && !host_busy) begin
            img_model[host_wr.addr] = host_wr.data;
            img_ok[host_wr.addr] = 1;
            frame_ok[host_wr.addr] = 0;
         end
         if (lv && !lv_q) begin
            if (line > 0 && cyc - lv_rise_cyc != line_cycles) begin
               $display("[ERROR] lv period expected %h actual %h",
                        line_cycles, cyc - lv_rise_cyc);
               err_cnt++;
            end
            lv_rise_cyc = cyc;
            col = 0;
         end
         if (lv) begin
            expected = ref_pixel(frame_mode, geom, line, col, frame_m, noise_m);
            addr = (line % 64) * 64 + (col % 64);
            if (frame_mode != 3'd6 || frame_ok[addr]) begin
               if (frame_mode == 3'd6) begin
                  img_checked++;
               end
               if (dat !== expected) begin
                  $display("[ERROR] dat row %0d col %0d expected %h actual %h",
                           line, col, expected, dat);
                  err_cnt++;
               end
            end
            noise_m = lfsr_step(noise_m);
            col++;
         end
         if (!lv && lv_q) begin
            if (!dropped && col != int'(geom.active_cols)) begin
               $display("[ERROR] lv length expected %h actual %h", geom.active_cols, col);
               err_cnt++;
            end
            line++;
         end
         if (!fv && fv_q) begin
            if (!dropped) begin
               if (line != int'(geom.active_rows)) begin
                  $display("[ERROR] lines per frame expected %h actual %h",
                           geom.active_rows, line);
                  err_cnt++;
               end
               frame_m++;
               frames_done++;
               vblank_seen = 1;
            end
            last_complete = !dropped;
            dropped = 0;
         end
         fv_q = fv;
         lv_q = lv;
      end
   end

endmodule

//--- sim/tb_imager.sv
module tb_imager;

   timeunit 1ns;
   timeprecision 1ps;

   // frames run by the sequence, image loading counted as ten
   localparam int TEST_FRAMES = 6 + 6 + 4 + 12 + 4;
   localparam int MAX_CYCLES  = TEST_FRAMES * 160 + 400;

   logic                      clk = 1'b0;
   logic                      reset_n;
   logic                      enable;
   sensor_pkg::pattern_mode_e mode;
   sensor_pkg::scan_geom_s    geom;
   sensor_pkg::noise_t        noise_seed;
   mem_pkg::mem_wr_s          host_wr;
   sensor_pkg::pix_t          dat;
   logic                      fv;
   logic                      lv;
   logic                      host_busy;

   int err_cnt;
   int frames_done;
   int img_checked;
   int cycles = 0;
   int seed = 64194;
   int total;

   always #50 clk = ~clk;

   imager_top dut (
      .clk        (clk),
      .reset_n    (reset_n),
      .enable     (enable),
      .mode       (mode),
      .geom       (geom),
      .noise_seed (noise_seed),
      .host_wr    (host_wr),
      .dat        (dat),
      .fv         (fv),
      .lv         (lv),
      .host_busy  (host_busy)
   );

   imager_monitor mon (
      .clk         (clk),
      .reset_n     (reset_n),
      .enable      (enable),
      .mode        (mode),
      .geom        (geom),
      .noise_seed  (noise_seed),
      .host_wr     (host_wr),
      .host_busy   (host_busy),
      .dat         (dat),
      .fv          (fv),
      .lv          (lv),
      .err_cnt     (err_cnt),
      .frames_done (frames_done),
      .img_checked (img_checked)
   );

   bind imager_top imager_chk chk (
      .clk       (clk),
      .reset_n   (reset_n),
      .enable    (enable),
      .geom      (geom),
      .dat       (dat),
      .fv        (fv),
      .lv        (lv),
      .host_busy (host_busy)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: sequence did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // returns on the edge where the end of a frame is seen
   task automatic wait_frame_end();
      do @(posedge clk); while (!fv);
      do @(posedge clk); while (fv);
   endtask

   task automatic host_write(input mem_pkg::addr_t addr, input sensor_pkg::pix_t data);
      host_wr <= {1'b1, addr, data};
      @(posedge clk);
      host_wr.valid <= 1'b0;
      do @(posedge clk); while (host_busy);
   endtask

   task automatic load_image();
      int r;
      int c;
      int d;
      for (int i = 0; i < 64; i++) begin
         r = $random(seed);
         c = $random(seed);
         d = $random(seed);
         host_write({6'((r & 32'h7fff_ffff) % 6), 6'((c & 32'h7fff_ffff) % 10)}, 10'(d));
      end
   endtask

   initial begin
      reset_n    = 1'b0;
      enable     = 1'b0;
      mode       = sensor_pkg::mode_hgrad;
      geom       = '{active_rows: 12'd6, virtual_rows: 12'd4,
                     active_cols: 12'd10, virtual_cols: 12'd6};
      noise_seed = '0;
      host_wr    = '0;
      repeat (8) @(posedge clk);
      reset_n <= 1'b1;
      repeat (3) @(posedge clk);
      enable <= 1'b1;

      // gradients, with geometry checked throughout
      repeat (2) wait_frame_end();
      mode <= sensor_pkg::mode_vgrad;
      repeat (2) wait_frame_end();
      mode <= sensor_pkg::mode_diag;
      repeat (2) wait_frame_end();

      // frame count patterns
      mode <= sensor_pkg::mode_frame;
      repeat (3) wait_frame_end();
      mode <= sensor_pkg::mode_frame_diag;
      repeat (3) wait_frame_end();

      // noise with a fixed seed for two frames, then free running
      mode       <= sensor_pkg::mode_noise;
      noise_seed <= 32'hace1_2345;
      wait_frame_end();
      // seed cleared inside the second frame, so the next vblank reloads nothing
      do @(posedge clk); while (!fv);
      noise_seed <= '0;
      repeat (3) wait_frame_end();

      // stored image loaded while the generator reads it
      mode <= sensor_pkg::mode_image;
      load_image();
      repeat (2) wait_frame_end();

      // disable in the middle of a frame
      mode <= sensor_pkg::mode_frame_diag;
      do @(posedge clk); while (!fv);
      repeat (40) @(posedge clk);
      enable <= 1'b0;
      repeat (10) @(posedge clk);
      enable <= 1'b1;
      repeat (2) wait_frame_end();
      repeat (4) @(posedge clk);

      total = err_cnt + dut.chk.fail_cnt;
      if (frames_done < 20) begin
         $display("too few complete frames seen: %0d", frames_done);
         total++;
      end
      if (img_checked == 0) begin
         $display("no stored image pixel was compared");
         total++;
      end
      $display("summary: %0d check errors, %0d assertion failures, %0d frames",
               err_cnt, dut.chk.fail_cnt, frames_done);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
verilog/sensor_pkg.sv
verilog/mem_pkg.sv
verilog/pattern_gen.sv
verilog/frame_mem.sv
verilog/mem_arbiter.sv
verilog/imager_top.sv
sim/imager_chk.sv
sim/imager_monitor.sv
sim/tb_imager.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_imager
RTL_TOP   ?= imager_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) \
		verilog/sensor_pkg.sv verilog/mem_pkg.sv verilog/pattern_gen.sv \
		verilog/frame_mem.sv verilog/mem_arbiter.sv verilog/imager_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
